// ==== Makefile ====
# Verilator build and run of the debug module testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_debug_module
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides the result, a missing pass line fails the target
run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/abstract_cmd_engine.sv ====
module abstract_cmd_engine (
	input logic clk,
	input logic reset,
	input logic cmd_start,
	input dm_pkg::dmi_word_t command,
	input dm_pkg::dmi_word_t data0,
	output logic busy,
	output logic result_stb,
	output dm_pkg::dmi_word_t result_data,
	output logic err_stb,
	output logic [2:0] err_code,
	output logic regfile_wen,
	output logic [dm_pkg::REG_ADDR_WIDTH-1:0] regfile_addr,
	output dm_pkg::dmi_word_t regfile_wdata,
	input dm_pkg::dmi_word_t regfile_rdata,
	output logic [dm_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
	output dm_pkg::csr_cmd_t csr_cmd,
	output dm_pkg::dmi_word_t csr_wdata,
	input dm_pkg::dmi_word_t csr_rdata,
	output logic hart0_postexecreq
);
	import dm_pkg::*;

	engine_state_t state;
	engine_state_t state_next;
	logic [7:0] cmd_type;			// cmdtype field
	logic [2:0] aarsize;			// access size
	logic postexec;
	logic transfer;
	logic write;
	logic [15:0] regno;
	logic gpr_sel;				// regno 0x1000 range
	logic [XLEN-1:0] read_value;

	// ====================
	// command fields
	// ====================

	assign cmd_type = command[31:24];
	assign aarsize = command[22:20];
	assign postexec = command[18];
	assign transfer = command[17];
	assign write = command[16];
	assign regno = command[15:0];
	assign gpr_sel = regno[12];		// low regno space is csr

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ENG_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = ENG_IDLE;
		case (state)
			ENG_IDLE: begin
				state_next = cmd_start ? ENG_DECODE : ENG_IDLE;	// start ignored when busy
			end
			ENG_DECODE: begin
				if (cmd_type != CMD_ACCESSREG) begin
					state_next = ENG_IDLE;	// other command types unsupported
				end else if (!transfer) begin
					state_next = postexec ? ENG_POSTEXEC : ENG_IDLE;
				end else if (aarsize != AARSIZE_32) begin
					state_next = ENG_ERR_NOTSUPP;
				end else begin
					state_next = write ? ENG_WRITE : ENG_READ;
				end
			end
			ENG_READ, ENG_WRITE: begin
				state_next = postexec ? ENG_POSTEXEC : ENG_IDLE;
			end
			ENG_POSTEXEC: state_next = ENG_IDLE;
			ENG_ERR_NOTSUPP: state_next = ENG_IDLE;
			default: state_next = ENG_IDLE;
		endcase
	end

	// ====================
	// hart access outputs
	// ====================

	assign busy = (state != ENG_IDLE);

	assign regfile_addr = regno[4:0];		// x0..x31
	assign regfile_wdata = data0;
	assign regfile_wen = (state == ENG_WRITE) && gpr_sel;

	assign csr_addr = regno[11:0];
	assign csr_wdata = data0;

	always_comb begin
		csr_cmd = CSR_IDLE;
		if (!gpr_sel) begin
			if (state == ENG_READ) begin
				csr_cmd = CSR_READ;
			end else if (state == ENG_WRITE) begin
				csr_cmd = CSR_WRITE;
			end
		end
	end

	assign read_value = gpr_sel ? regfile_rdata : csr_rdata;	// same cycle read
	assign result_data = read_value;
	assign result_stb = (state == ENG_READ);

	assign err_stb = (state == ENG_ERR_NOTSUPP);
	assign err_code = CMDERR_NOTSUPP;

	assign hart0_postexecreq = (state == ENG_POSTEXEC);	// one cycle request

endmodule

// ==== hdl/debug_module.sv ====
module debug_module (
	input logic clk,
	input logic reset,

	// ====================
	// dmi bus
	// ====================
	input logic dmi_en,
	input logic dmi_wen,
	input dm_pkg::dmi_addr_t dmi_addr,
	input dm_pkg::dmi_word_t dmi_wdata,
	output dm_pkg::dmi_word_t dmi_rdata,

	// ====================
	// register access
	// ====================
	output logic regfile_wen,
	output logic [dm_pkg::REG_ADDR_WIDTH-1:0] regfile_addr,
	output dm_pkg::dmi_word_t regfile_wdata,
	input dm_pkg::dmi_word_t regfile_rdata,
	output logic [dm_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
	output dm_pkg::csr_cmd_t csr_cmd,
	output dm_pkg::dmi_word_t csr_wdata,
	input dm_pkg::dmi_word_t csr_rdata,

	// ====================
	// run control
	// ====================
	output logic hart0_haltreq,
	output logic hart0_resumereq,
	input logic hart0_halted,
	input logic hart0_resumeack,
	output logic hart0_postexecreq,
	output dm_pkg::dmi_word_t hart0_progbuf0,
	output dm_pkg::dmi_word_t hart0_progbuf1
);
	import dm_pkg::*;

	dmi_addr_t reg_addr;			// captured dmi address
	dmi_word_t reg_wdata;
	dmi_word_t rd_data;
	logic wr_stb;
	logic cmd_start;
	dmi_word_t command;
	dmi_word_t data0;
	logic busy;
	logic result_stb;
	dmi_word_t result_data;
	logic err_stb;
	logic [2:0] err_code;

	dmi_bus_slave i_dmi_bus_slave (
		.clk(clk),
		.reset(reset),
		.dmi_en(dmi_en),
		.dmi_wen(dmi_wen),
		.dmi_addr(dmi_addr),
		.dmi_wdata(dmi_wdata),
		.dmi_rdata(dmi_rdata),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.wr_stb(wr_stb),
		.rd_data(rd_data)
	);

	dm_registers i_dm_registers (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.wr_stb(wr_stb),
		.rd_data(rd_data),
		.cmd_start(cmd_start),
		.command(command),
		.data0(data0),
		.busy(busy),
		.result_stb(result_stb),
		.result_data(result_data),
		.err_stb(err_stb),
		.err_code(err_code),
		.hart0_halted(hart0_halted),
		.hart0_resumeack(hart0_resumeack),
		.hart0_haltreq(hart0_haltreq),
		.hart0_resumereq(hart0_resumereq),
		.hart0_progbuf0(hart0_progbuf0),
		.hart0_progbuf1(hart0_progbuf1)
	);

	abstract_cmd_engine i_abstract_cmd_engine (
		.clk(clk),
		.reset(reset),
		.cmd_start(cmd_start),
		.command(command),
		.data0(data0),
		.busy(busy),
		.result_stb(result_stb),
		.result_data(result_data),
		.err_stb(err_stb),
		.err_code(err_code),
		.regfile_wen(regfile_wen),
		.regfile_addr(regfile_addr),
		.regfile_wdata(regfile_wdata),
		.regfile_rdata(regfile_rdata),
		.csr_addr(csr_addr),
		.csr_cmd(csr_cmd),
		.csr_wdata(csr_wdata),
		.csr_rdata(csr_rdata),
		.hart0_postexecreq(hart0_postexecreq)
	);

endmodule

// ==== hdl/dm_pkg.sv ====
package dm_pkg;

	// ====================
	// widths and word types
	// ====================

	localparam int DMI_ADDR_WIDTH = 7;		// dmi address bits
	localparam int DMI_WIDTH = 32;			// dmi data bits
	localparam int XLEN = 32;			// hart register width
	localparam int REG_ADDR_WIDTH = 5;		// gpr index
	localparam int CSR_ADDR_WIDTH = 12;		// csr address
	localparam int CSR_CMD_WIDTH = 3;		// csr command

	typedef logic [DMI_ADDR_WIDTH-1:0] dmi_addr_t;
	typedef logic [DMI_WIDTH-1:0] dmi_word_t;
	typedef logic [CSR_CMD_WIDTH-1:0] csr_cmd_t;

	// ====================
	// dmi register map
	// ====================

	localparam dmi_addr_t ADDR_DATA0 = 7'h04;
	localparam dmi_addr_t ADDR_DMCONTROL = 7'h10;
	localparam dmi_addr_t ADDR_DMSTATUS = 7'h11;
	localparam dmi_addr_t ADDR_HARTINFO = 7'h12;
	localparam dmi_addr_t ADDR_ABSTRACTCS = 7'h16;
	localparam dmi_addr_t ADDR_COMMAND = 7'h17;
	localparam dmi_addr_t ADDR_ABSTRACTAUTO = 7'h18;
	localparam dmi_addr_t ADDR_PROGBUF0 = 7'h20;
	localparam dmi_addr_t ADDR_PROGBUF1 = 7'h21;

	// ====================
	// commands and codes
	// ====================

	localparam csr_cmd_t CSR_IDLE = 3'd0;		// no csr access
	localparam csr_cmd_t CSR_READ = 3'd4;
	localparam csr_cmd_t CSR_WRITE = 3'd5;

	localparam logic [2:0] CMDERR_NONE = 3'd0;
	localparam logic [2:0] CMDERR_NOTSUPP = 3'd2;	// unsupported access size

	localparam logic [7:0] CMD_ACCESSREG = 8'd0;	// cmdtype of access register
	localparam logic [2:0] AARSIZE_32 = 3'd2;	// only 32 bit transfers

	// ====================
	// reset and fixed values
	// ====================

	localparam dmi_word_t NOP_INSN = 32'h0000_0013;	// addi x0, x0, 0
	localparam dmi_word_t DATA0_RESET = 32'hbabe_babe;
	localparam dmi_word_t UNMAPPED_RDATA = 32'hdead_dead;
	localparam logic [3:0] DM_VERSION = 4'd2;	// debug spec 0.13
	localparam logic [4:0] PROGBUF_SIZE = 5'd2;
	localparam logic [4:0] DATA_COUNT = 5'd1;	// data0 only
	localparam dmi_word_t HARTINFO_VALUE = 32'h0001_1043;

	// ====================
	// state encodings
	// ====================

	typedef enum logic [1:0] {
		DMI_IDLE,		// wait for synced enable
		DMI_READ,		// one cycle read slot
		DMI_WRITE,		// one cycle write slot
		DMI_WAITEND		// wait for enable to drop
	} dmi_state_t;

	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_DECODE,		// look at command fields
		ENG_READ,		// capture gpr or csr value
		ENG_WRITE,		// drive gpr or csr write
		ENG_POSTEXEC,		// kick the program buffer
		ENG_ERR_NOTSUPP		// report unsupported size
	} engine_state_t;

endpackage

// ==== hdl/dm_registers.sv ====
module dm_registers (
	input logic clk,
	input logic reset,
	input dm_pkg::dmi_addr_t reg_addr,
	input dm_pkg::dmi_word_t reg_wdata,
	input logic wr_stb,
	output dm_pkg::dmi_word_t rd_data,
	output logic cmd_start,
	output dm_pkg::dmi_word_t command,
	output dm_pkg::dmi_word_t data0,
	input logic busy,
	input logic result_stb,
	input dm_pkg::dmi_word_t result_data,
	input logic err_stb,
	input logic [2:0] err_code,
	input logic hart0_halted,
	input logic hart0_resumeack,
	output logic hart0_haltreq,
	output logic hart0_resumereq,
	output dm_pkg::dmi_word_t hart0_progbuf0,
	output dm_pkg::dmi_word_t hart0_progbuf1
);
	import dm_pkg::*;

	logic [9:0] hartsel;			// dmcontrol hart index
	logic ndmreset;
	logic dmactive;
	logic [2:0] cmderr;
	logic anyhalted;			// sampled from the hart
	logic anyrunning;
	logic anynonexistent;
	dmi_word_t abstractauto;
	dmi_word_t dmstatus;
	dmi_word_t abstractcs;
	dmi_word_t dmcontrol_rd;
	logic autoexec;

	// ====================
	// register writes
	// ====================

	always_ff @(posedge clk) begin
		if (reset) begin
			hart0_haltreq <= 1'b0;
			hart0_resumereq <= 1'b0;
			hartsel <= '0;
			ndmreset <= 1'b0;
			dmactive <= 1'b0;
			cmderr <= CMDERR_NONE;
			anyhalted <= 1'b0;
			anyrunning <= 1'b1;
			command <= '0;
			data0 <= DATA0_RESET;
			hart0_progbuf0 <= NOP_INSN;	// progbuf starts as nops
			hart0_progbuf1 <= NOP_INSN;
			abstractauto <= '0;
		end else begin
			anyhalted <= hart0_halted;
			anyrunning <= ~hart0_halted;
			if (wr_stb) begin
				case (reg_addr)
					ADDR_DATA0: data0 <= reg_wdata;
					ADDR_DMCONTROL: begin
						hart0_haltreq <= reg_wdata[31];
						hart0_resumereq <= reg_wdata[30];
						hartsel <= reg_wdata[25:16];
						ndmreset <= reg_wdata[1];
						dmactive <= reg_wdata[0];
					end
					ADDR_ABSTRACTCS: cmderr <= CMDERR_NONE;	// write clears cmderr
					ADDR_COMMAND: command <= reg_wdata;
					ADDR_ABSTRACTAUTO: abstractauto <= reg_wdata;
					ADDR_PROGBUF0: hart0_progbuf0 <= reg_wdata;
					ADDR_PROGBUF1: hart0_progbuf1 <= reg_wdata;
					default: ;
				endcase
			end else begin
				if (result_stb) begin
					data0 <= result_data;	// abstract read result
				end
				if (err_stb) begin
					cmderr <= err_code;
				end
			end
		end
	end

	// ====================
	// command start
	// ====================

	always_comb begin
		autoexec = 1'b0;
		case (reg_addr)
			ADDR_DATA0: autoexec = abstractauto[0];
			ADDR_PROGBUF0: autoexec = abstractauto[16];
			ADDR_PROGBUF1: autoexec = abstractauto[17];
			default: autoexec = 1'b0;
		endcase
	end

	// engine sees the new command word on its decode cycle
	assign cmd_start = wr_stb && (reg_addr == ADDR_COMMAND || autoexec);

	// ====================
	// read side
	// ====================

	assign anynonexistent = |hartsel;		// only hart 0 exists

	assign dmstatus = {9'b0, 1'b1, 2'b00,		// impebreak set
		2'b00,					// no havereset
		{2{hart0_resumeack}},
		{2{anynonexistent}},
		2'b00,					// never unavailable
		{2{anyrunning}},
		{2{anyhalted}},
		1'b1, 1'b0, 1'b0, 1'b0,		// authenticated, no devtree
		DM_VERSION};

	assign abstractcs = {3'b0, PROGBUF_SIZE, 11'b0, busy, 1'b0, cmderr, 3'b0, DATA_COUNT};

	assign dmcontrol_rd = {30'b0, ndmreset, dmactive};

	always_comb begin
		case (reg_addr)
			ADDR_DATA0: rd_data = data0;
			ADDR_DMCONTROL: rd_data = dmcontrol_rd;
			ADDR_DMSTATUS: rd_data = dmstatus;
			ADDR_HARTINFO: rd_data = HARTINFO_VALUE;
			ADDR_ABSTRACTCS: rd_data = abstractcs;
			ADDR_COMMAND: rd_data = command;
			ADDR_ABSTRACTAUTO: rd_data = abstractauto;
			ADDR_PROGBUF0: rd_data = hart0_progbuf0;
			ADDR_PROGBUF1: rd_data = hart0_progbuf1;
			default: rd_data = UNMAPPED_RDATA;
		endcase
	end

endmodule

// ==== hdl/dmi_bus_slave.sv ====
module dmi_bus_slave (
	input logic clk,
	input logic reset,
	input logic dmi_en,
	input logic dmi_wen,
	input dm_pkg::dmi_addr_t dmi_addr,
	input dm_pkg::dmi_word_t dmi_wdata,
	output dm_pkg::dmi_word_t dmi_rdata,
	output dm_pkg::dmi_addr_t reg_addr,
	output dm_pkg::dmi_word_t reg_wdata,
	output logic wr_stb,
	input dm_pkg::dmi_word_t rd_data
);
	import dm_pkg::*;

	logic en_sync1;				// first synchronizer flop
	logic en_sync2;				// second flop, drives the sequencer
	logic wen_r;				// captured write flag
	dmi_state_t state;
	dmi_state_t state_next;

	// ====================
	// sync and sequencer
	// ====================

	always_ff @(posedge clk) begin
		if (reset) begin
			en_sync1 <= 1'b0;
			en_sync2 <= 1'b0;
			wen_r <= 1'b0;
			state <= DMI_IDLE;
		end else begin
			en_sync1 <= dmi_en;
			en_sync2 <= en_sync1;
			state <= state_next;
			if (en_sync1 && state == DMI_IDLE) begin
				wen_r <= dmi_wen;	// host holds wen with the enable
			end
		end
	end

	// address and data are stable while the host holds dmi_en
	always_ff @(posedge clk) begin
		if (en_sync1 && state == DMI_IDLE) begin
			reg_addr <= dmi_addr;
			reg_wdata <= dmi_wdata;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			DMI_IDLE: begin
				if (en_sync2) begin
					state_next = wen_r ? DMI_WRITE : DMI_READ;
				end
			end
			DMI_READ: state_next = DMI_WAITEND;
			DMI_WRITE: state_next = DMI_WAITEND;
			DMI_WAITEND: begin
				if (!en_sync2) begin
					state_next = DMI_IDLE;	// transaction closed by host
				end
			end
			default: state_next = DMI_IDLE;
		endcase
	end

	assign wr_stb = (state == DMI_WRITE);		// single cycle per write

	// read data follows the register file every cycle
	always_ff @(posedge clk) begin
		dmi_rdata <= rd_data;
	end

endmodule

// ==== sim/hart_model.sv ====
module hart_model (
	input logic clk,
	input logic reset,
	input logic regfile_wen,
	input logic [dm_pkg::REG_ADDR_WIDTH-1:0] regfile_addr,
	input dm_pkg::dmi_word_t regfile_wdata,
	output dm_pkg::dmi_word_t regfile_rdata,
	input logic [dm_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
	input dm_pkg::csr_cmd_t csr_cmd,
	input dm_pkg::dmi_word_t csr_wdata,
	output dm_pkg::dmi_word_t csr_rdata,
	input logic postexecreq,
	output logic [31:0] postexec_count
);
	import dm_pkg::*;

	dmi_word_t gpr [0:31];			// x0..x31, x0 not hardwired here
	dmi_word_t csr_mem [0:4095];		// full 12 bit csr space

	// ====================
	// register files
	// ====================

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				gpr[i[4:0]] <= 32'hc0de_0000 | i;	// pattern from index
			end
			for (int i = 0; i < 4096; i++) begin
				csr_mem[i[11:0]] <= 32'h5a5a_0000 | i;
			end
		end else begin
			if (regfile_wen) begin
				gpr[regfile_addr] <= regfile_wdata;
			end
			if (csr_cmd == CSR_WRITE) begin
				csr_mem[csr_addr] <= csr_wdata;
			end
		end
	end

	assign regfile_rdata = gpr[regfile_addr];	// same cycle answer

	// csr port only answers an explicit read
	assign csr_rdata = (csr_cmd == CSR_READ) ? csr_mem[csr_addr] : 32'd0;

	// ====================
	// program buffer kicks
	// ====================

	always @(posedge clk) begin
		if (reset) begin
			postexec_count <= 32'd0;
		end else if (postexecreq) begin
			postexec_count <= postexec_count + 32'd1;	// one per request cycle
		end
	end

endmodule

// ==== sim/tb_debug_module.sv ====
module tb_debug_module;
	import dm_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int SEED = 68;
	localparam int N_ROUNDS = 8;			// random rounds per test
	localparam int NUM_TXNS = 40 + 20 * N_ROUNDS;	// dmi transactions, rounded up
	localparam int WATCHDOG_CYCLES = NUM_TXNS * 12 + 200;

	logic clk = 1'b0;
	logic reset;
	logic dmi_en;
	logic dmi_wen;
	dmi_addr_t dmi_addr;
	dmi_word_t dmi_wdata;
	dmi_word_t dmi_rdata;
	logic regfile_wen;
	logic [REG_ADDR_WIDTH-1:0] regfile_addr;
	dmi_word_t regfile_wdata;
	dmi_word_t regfile_rdata;
	logic [CSR_ADDR_WIDTH-1:0] csr_addr;
	csr_cmd_t csr_cmd;
	dmi_word_t csr_wdata;
	dmi_word_t csr_rdata;
	logic hart0_haltreq;
	logic hart0_resumereq;
	logic hart0_halted;
	logic hart0_resumeack;
	logic hart0_postexecreq;
	dmi_word_t hart0_progbuf0;
	dmi_word_t hart0_progbuf1;
	logic [31:0] postexec_count;

	// shadow of what the host has written
	dmi_word_t sh_data0;
	dmi_word_t sh_command;
	dmi_word_t sh_abstractauto;
	dmi_word_t sh_progbuf0;
	dmi_word_t sh_progbuf1;
	logic [9:0] sh_hartsel;
	logic sh_ndmreset;
	logic sh_dmactive;
	logic sh_haltreq;
	logic sh_resumereq;
	logic [2:0] sh_cmderr;
	dmi_word_t sh_gpr [0:31];
	dmi_word_t sh_csr [0:4095];
	logic [31:0] sh_postexec;		// expected postexec pulses

	string name_q[$];			// pending checks
	dmi_word_t exp_q[$];
	dmi_word_t act_q[$];
	int error_count = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	debug_module i_debug_module (.*);

	hart_model i_hart_model (
		.clk(clk),
		.reset(reset),
		.regfile_wen(regfile_wen),
		.regfile_addr(regfile_addr),
		.regfile_wdata(regfile_wdata),
		.regfile_rdata(regfile_rdata),
		.csr_addr(csr_addr),
		.csr_cmd(csr_cmd),
		.csr_wdata(csr_wdata),
		.csr_rdata(csr_rdata),
		.postexecreq(hart0_postexecreq),
		.postexec_count(postexec_count)
	);

	// ====================
	// reference model
	// ====================

	function automatic dmi_word_t expected_read(input dmi_addr_t addr);
		dmi_word_t value;
		value = 32'hdead_dead;			// unmapped answer
		case (addr)
			ADDR_DATA0: value = sh_data0;
			ADDR_DMCONTROL: value = {30'd0, sh_ndmreset, sh_dmactive};
			ADDR_DMSTATUS: begin
				value = 32'd0;
				value[3:0] = 4'd2;		// version 0.13
				value[7] = 1'b1;		// authenticated
				value[9:8] = {2{hart0_halted}};
				value[11:10] = {2{~hart0_halted}};
				value[15:14] = {2{sh_hartsel != 10'd0}};
				value[17:16] = {2{hart0_resumeack}};
				value[22] = 1'b1;		// impebreak
			end
			ADDR_HARTINFO: value = 32'h0001_1043;
			ADDR_ABSTRACTCS: begin
				value = 32'd0;
				value[28:24] = 5'd2;		// progbufsize
				value[10:8] = sh_cmderr;	// busy is 0 by read time
				value[3:0] = 4'd1;		// datacount
			end
			ADDR_COMMAND: value = sh_command;
			ADDR_ABSTRACTAUTO: value = sh_abstractauto;
			ADDR_PROGBUF0: value = sh_progbuf0;
			ADDR_PROGBUF1: value = sh_progbuf1;
			default: ;
		endcase
		return value;
	endfunction

	function automatic dmi_word_t access_cmd(input logic postexec, input logic transfer,
			input logic write, input logic [2:0] size, input logic [15:0] regno);
		return {8'h00, 1'b0, size, 1'b0, postexec, transfer, write, regno};
	endfunction

	// effect of one abstract command on the shadow
	task automatic model_command(input dmi_word_t cmd);
		logic [15:0] regno;
		regno = cmd[15:0];
		if (cmd[31:24] == 8'd0) begin
			if (cmd[17] && cmd[22:20] != 3'd2) begin
				sh_cmderr = 3'd2;		// not supported, no postexec
			end else begin
				if (cmd[17] && cmd[16]) begin
					if (regno[12]) begin
						sh_gpr[regno[4:0]] = sh_data0;
					end else begin
						sh_csr[regno[11:0]] = sh_data0;
					end
				end else if (cmd[17]) begin
					sh_data0 = regno[12] ? sh_gpr[regno[4:0]] : sh_csr[regno[11:0]];
				end
				if (cmd[18]) begin
					sh_postexec = sh_postexec + 32'd1;
				end
			end
		end
	endtask

	task automatic update_shadow(input dmi_addr_t addr, input dmi_word_t data);
		case (addr)
			ADDR_DATA0: begin
				sh_data0 = data;
				if (sh_abstractauto[0]) model_command(sh_command);	// autoexec
			end
			ADDR_DMCONTROL: begin
				sh_haltreq = data[31];
				sh_resumereq = data[30];
				sh_hartsel = data[25:16];
				sh_ndmreset = data[1];
				sh_dmactive = data[0];
			end
			ADDR_ABSTRACTCS: sh_cmderr = 3'd0;	// any write clears
			ADDR_COMMAND: begin
				sh_command = data;
				model_command(data);
			end
			ADDR_ABSTRACTAUTO: sh_abstractauto = data;
			ADDR_PROGBUF0: begin
				sh_progbuf0 = data;
				if (sh_abstractauto[16]) model_command(sh_command);
			end
			ADDR_PROGBUF1: begin
				sh_progbuf1 = data;
				if (sh_abstractauto[17]) model_command(sh_command);
			end
			default: ;
		endcase
	endtask

	// ====================
	// dmi host and checks
	// ====================

	task automatic dmi_write(input dmi_addr_t addr, input dmi_word_t data);
		@(negedge clk);
		dmi_addr = addr;
		dmi_wdata = data;
		dmi_wen = 1'b1;
		dmi_en = 1'b1;
		repeat (6) @(negedge clk);		// host holds the transaction
		dmi_en = 1'b0;
		dmi_wen = 1'b0;
		repeat (4) @(negedge clk);		// idle gap
		update_shadow(addr, data);
	endtask

	task automatic dmi_read(input dmi_addr_t addr, output dmi_word_t data);
		@(negedge clk);
		dmi_addr = addr;
		dmi_wdata = 32'd0;
		dmi_wen = 1'b0;
		dmi_en = 1'b1;
		repeat (6) @(negedge clk);
		data = dmi_rdata;			// stable while enable held
		dmi_en = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	function automatic void queue_check(input string name, input dmi_word_t expected,
			input dmi_word_t actual);
		name_q.push_back(name);
		exp_q.push_back(expected);
		act_q.push_back(actual);
	endfunction

	task automatic read_and_compare(input string name, input dmi_addr_t addr);
		dmi_word_t data;
		dmi_read(addr, data);
		queue_check(name, expected_read(addr), data);
	endtask

	task automatic check_value(input string name, input dmi_word_t expected,
			input dmi_word_t actual);
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	always @(posedge clk) begin			// queue filled on falling edges
		while (exp_q.size() != 0) begin
			check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	// ====================
	// stimulus
	// ====================

	initial begin : stimulus
		dmi_word_t rnd;
		logic [4:0] idx;
		logic [11:0] csr_sel;
		logic [15:0] regno;
		void'($urandom(SEED));
		reset = 1'b1;
		dmi_en = 1'b0;
		dmi_wen = 1'b0;
		dmi_addr = '0;
		dmi_wdata = '0;
		hart0_halted = 1'b0;
		hart0_resumeack = 1'b0;
		sh_data0 = 32'hbabe_babe;
		sh_command = 32'd0;
		sh_abstractauto = 32'd0;
		sh_progbuf0 = 32'h0000_0013;		// nop
		sh_progbuf1 = 32'h0000_0013;
		sh_hartsel = 10'd0;
		sh_ndmreset = 1'b0;
		sh_dmactive = 1'b0;
		sh_haltreq = 1'b0;
		sh_resumereq = 1'b0;
		sh_cmderr = 3'd0;
		sh_postexec = 32'd0;
		for (int i = 0; i < 32; i++) sh_gpr[i[4:0]] = 32'hc0de_0000 | i;
		for (int i = 0; i < 4096; i++) sh_csr[i[11:0]] = 32'h5a5a_0000 | i;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		read_and_compare("reset data0", ADDR_DATA0);
		read_and_compare("reset progbuf0", ADDR_PROGBUF0);
		read_and_compare("reset progbuf1", ADDR_PROGBUF1);
		read_and_compare("reset abstractcs", ADDR_ABSTRACTCS);
		read_and_compare("reset hartinfo", ADDR_HARTINFO);
		read_and_compare("reset dmstatus", ADDR_DMSTATUS);
		read_and_compare("unmapped 0x00", 7'h00);
		read_and_compare("unmapped hawindow", 7'h15);
		read_and_compare("unmapped 0x7f", 7'h7f);

		for (int r = 0; r < N_ROUNDS; r++) begin	// plain register readback
			dmi_write(ADDR_DATA0, $urandom);
			dmi_write(ADDR_PROGBUF0, $urandom);
			dmi_write(ADDR_PROGBUF1, $urandom);
			dmi_write(ADDR_ABSTRACTAUTO, $urandom);
			read_and_compare("data0 readback", ADDR_DATA0);
			read_and_compare("progbuf0 readback", ADDR_PROGBUF0);
			read_and_compare("progbuf1 readback", ADDR_PROGBUF1);
			read_and_compare("abstractauto readback", ADDR_ABSTRACTAUTO);
			queue_check("hart0_progbuf0 port", sh_progbuf0, hart0_progbuf0);
			queue_check("hart0_progbuf1 port", sh_progbuf1, hart0_progbuf1);
		end
		dmi_write(ADDR_ABSTRACTAUTO, 32'd0);

		for (int r = 0; r < N_ROUNDS; r++) begin
			rnd = $urandom;
			dmi_write(ADDR_DMCONTROL, rnd);
			read_and_compare("dmcontrol readback", ADDR_DMCONTROL);
			queue_check("hart0_haltreq", {31'd0, sh_haltreq}, {31'd0, hart0_haltreq});
			queue_check("hart0_resumereq", {31'd0, sh_resumereq}, {31'd0, hart0_resumereq});
		end
		dmi_write(ADDR_DMCONTROL, 32'h0000_0001);	// active, hart 0

		hart0_halted = 1'b1;
		read_and_compare("dmstatus halted", ADDR_DMSTATUS);
		hart0_halted = 1'b0;
		read_and_compare("dmstatus running", ADDR_DMSTATUS);
		hart0_resumeack = 1'b1;
		read_and_compare("dmstatus resumeack", ADDR_DMSTATUS);
		hart0_resumeack = 1'b0;
		dmi_write(ADDR_DMCONTROL, 32'h0005_0001);	// hartsel 5 does not exist
		read_and_compare("dmstatus nonexistent", ADDR_DMSTATUS);
		dmi_write(ADDR_DMCONTROL, 32'h0000_0001);
		read_and_compare("dmstatus hart 0", ADDR_DMSTATUS);

		for (int r = 0; r < N_ROUNDS; r++) begin	// gpr write then read back
			rnd = $urandom;
			idx = rnd[4:0];
			regno = 16'h1000 | {11'd0, idx};
			dmi_write(ADDR_DATA0, $urandom);
			dmi_write(ADDR_COMMAND, access_cmd(1'b0, 1'b1, 1'b1, 3'd2, regno));
			dmi_write(ADDR_DATA0, $urandom);	// overwrite before the read
			dmi_write(ADDR_COMMAND, access_cmd(1'b0, 1'b1, 1'b0, 3'd2, regno));
			read_and_compare($sformatf("gpr x%0d via data0", idx), ADDR_DATA0);
			queue_check($sformatf("gpr x%0d contents", idx), sh_gpr[idx],
				i_hart_model.gpr[idx]);
		end

		for (int r = 0; r < N_ROUNDS; r++) begin	// same for csr space
			rnd = $urandom;
			csr_sel = rnd[11:0];
			regno = {4'h0, csr_sel};
			dmi_write(ADDR_DATA0, $urandom);
			dmi_write(ADDR_COMMAND, access_cmd(1'b0, 1'b1, 1'b1, 3'd2, regno));
			dmi_write(ADDR_DATA0, $urandom);
			dmi_write(ADDR_COMMAND, access_cmd(1'b0, 1'b1, 1'b0, 3'd2, regno));
			read_and_compare($sformatf("csr 0x%h via data0", csr_sel), ADDR_DATA0);
			queue_check($sformatf("csr 0x%h contents", csr_sel), sh_csr[csr_sel],
				i_hart_model.csr_mem[csr_sel]);
		end

		dmi_write(ADDR_COMMAND, access_cmd(1'b1, 1'b1, 1'b0, 3'd3, 16'h1001));	// 64 bit
		read_and_compare("cmderr after 64 bit access", ADDR_ABSTRACTCS);
		queue_check("no postexec on error", sh_postexec, postexec_count);
		dmi_write(ADDR_ABSTRACTCS, 32'h0000_0700);
		read_and_compare("cmderr cleared", ADDR_ABSTRACTCS);
		dmi_write(ADDR_COMMAND, access_cmd(1'b1, 1'b1, 1'b1, 3'd2, 16'h1002));
		queue_check("postexec after gpr write", sh_postexec, postexec_count);
		dmi_write(ADDR_COMMAND, access_cmd(1'b1, 1'b0, 1'b0, 3'd2, 16'h0000));
		queue_check("postexec without transfer", sh_postexec, postexec_count);

		rnd = $urandom;
		idx = rnd[4:0];
		regno = 16'h1000 | {11'd0, idx};
		dmi_write(ADDR_COMMAND, access_cmd(1'b0, 1'b1, 1'b1, 3'd2, regno));
		dmi_write(ADDR_ABSTRACTAUTO, 32'h0000_0001);	// rerun on data0 write
		dmi_write(ADDR_DATA0, $urandom);
		queue_check($sformatf("autoexec gpr x%0d", idx), sh_gpr[idx], i_hart_model.gpr[idx]);
		dmi_write(ADDR_ABSTRACTAUTO, 32'd0);
		read_and_compare("abstractauto cleared", ADDR_ABSTRACTAUTO);
		queue_check("postexec total", sh_postexec, postexec_count);

		repeat (2) @(negedge clk);			// let the compare process drain
		if (error_count == 0 && exp_q.size() == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/dm_pkg.sv
hdl/dmi_bus_slave.sv
hdl/dm_registers.sv
hdl/abstract_cmd_engine.sv
hdl/debug_module.sv
sim/hart_model.sv
sim/tb_debug_module.sv
